//--- tests/knn_wb_vectors.txt
# op addr wdata expect, all hex; w writes wdata, r reads and compares with expect
# leaf address: bank in bits 5:3, entry in bits 11:6, upper half when bit 2 is set
r 30000000 00000000 00000000
r 30000004 00000000 00000000
r 30000008 00000000 00000000
w 30000000 00000001 00000000
w 30000004 00000001 00000000
w 30000008 00000003 00000000
r 30000000 00000000 00000001
r 30000004 00000000 00000001
r 30000008 00000000 00000001
w 30000000 00000000 00000000
w 30000004 00000002 00000000
w 30000008 fffffffe 00000000
r 30000000 00000000 00000000
w 30010000 89abcdef 00000000
w 30010004 fedcba98 00000000
w 30010f68 13579bdf 00000000
w 30010f6c 7fffffff 00000000
r 30010000 00000000 89abcdef
r 30010004 00000000 005cba98
r 30010f68 00000000 13579bdf
r 30010f6c 00000000 007fffff
w 30020140 a0000005 00000000
w 30020144 b0000005 00000000
w 30020148 a0010005 00000000
w 3002014c b0010005 00000000
w 30020150 a0020005 00000000
w 30020154 b0020005 00000000
w 30020158 a0030005 00000000
w 3002015c b0030005 00000000
w 30020160 a0040005 00000000
w 30020164 b0040005 00000000
w 30020168 a0050005 00000000
w 3002016c b0050005 00000000
w 30020170 a0060005 00000000
w 30020174 b0060005 00000000
w 30020178 a0070005 00000000
w 3002017c b0070005 00000000
w 30020ff0 0123abcd 00000000
w 30020ff4 89ef4567 00000000
r 30020144 00000000 b0000005
r 30020148 00000000 a0010005
r 30020150 00000000 a0020005
r 3002015c 00000000 b0030005
r 30020160 00000000 a0040005
r 3002016c 00000000 b0050005
r 30020170 00000000 a0060005
r 3002017c 00000000 b0070005
r 30020ff0 00000000 0123abcd
r 30020ff4 00000000 89ef4567
w 30040000 cafef00d 00000000
w 30040124 00000049 00000000
w 300403fc 12345678 00000000
r 30040000 00000000 cafef00d
r 30040124 00000000 00000049
r 300403fc 00000000 12345678
w 30030000 deadbeef 00000000
r 30030000 00000000 00000000
r 3000000c 00000000 00000000
r 30040000 00000000 cafef00d

//--- project.f
+incdir+hw
hw/knn_wb_pkg.sv
hw/sram_1rw.sv
hw/wbs_ctrl.sv
hw/knn_wb_top.sv
tests/wb_clk_gen.sv
tests/knn_wb_monitor.sv
tests/knn_wb_chk.sv
tests/knn_wb_tb.sv

//--- Makefile
TOP := knn_wb_tb

all: run

build:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -o $(TOP)

run: build
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)
	verilator --lint-only +incdir+hw hw/knn_wb_pkg.sv hw/sram_1rw.sv hw/wbs_ctrl.sv \
		hw/knn_wb_top.sv --top-module knn_wb_top

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

//--- tests/knn_wb_tb.sv
`timescale 1ns/1ps

module knn_wb_tb;

    localparam string       VEC_FILE  = "tests/knn_wb_vectors.txt";
    localparam logic [31:0] LFSR_SEED = 32'h39ed_e8ce;

    logic        wb_clk;
    logic        wb_rst;
    logic        wbs_cyc;
    logic        wbs_stb;
    logic        wbs_we;
    logic [3:0]  wbs_sel;
    logic [31:0] wbs_adr;
    logic [31:0] wbs_wdat;
    logic [31:0] exp_dat;
    logic        wbs_ack;
    logic [31:0] wbs_rdat;
    logic        mode;
    logic        debug;
    logic        done;
    logic [31:0] lfsr;
    int          mon_errs;
    int          other_errs  = 0;
    int          cycle_cnt   = 0;
    int          cycle_limit = 0;

    logic [7:0]  op_q   [$];
    logic [31:0] adr_q  [$];
    logic [31:0] wdat_q [$];
    logic [31:0] exp_q  [$];

    wb_clk_gen u_wb_clk_gen (
        .clk_o (wb_clk),
        .rst_o (wb_rst)
    );

    knn_wb_top u_knn_wb_top (
        .wb_clk_i  (wb_clk),
        .wb_rst_i  (wb_rst),
        .wbs_cyc_i (wbs_cyc),
        .wbs_stb_i (wbs_stb),
        .wbs_we_i  (wbs_we),
        .wbs_sel_i (wbs_sel),
        .wbs_adr_i (wbs_adr),
        .wbs_dat_i (wbs_wdat),
        .wbs_ack_o (wbs_ack),
        .wbs_dat_o (wbs_rdat),
        .mode_o    (mode),
        .debug_o   (debug),
        .done_o    (done)
    );

    knn_wb_monitor u_knn_wb_monitor (
        .wb_clk_i  (wb_clk),
        .wb_rst_i  (wb_rst),
        .wbs_cyc_i (wbs_cyc),
        .wbs_stb_i (wbs_stb),
        .wbs_we_i  (wbs_we),
        .wbs_adr_i (wbs_adr),
        .wbs_dat_i (wbs_wdat),
        .ack_i     (wbs_ack),
        .rd_dat_i  (wbs_rdat),
        .mode_i    (mode),
        .debug_i   (debug),
        .done_i    (done),
        .exp_dat_i (exp_dat),
        .err_cnt_o (mon_errs)
    );

    // fibonacci lfsr, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [31:0] adr;
        logic [31:0] wdat;
        logic [31:0] expd;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            other_errs++;
            $display("could not open vector file %s", VEC_FILE);
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%c %h %h %h", op, adr, wdat, expd);
                if (n == 4 && (op == "w" || op == "r")) begin
                    op_q.push_back(op);
                    adr_q.push_back(adr);
                    wdat_q.push_back(wdat);
                    exp_q.push_back(expd);
                end else begin
                    other_errs++;
                    $display("could not parse vector line: %s", line);
                end
            end
        end
        $fclose(fd);
    endtask

    // idle gap of 0 to 3 cycles, then hold the request through the ack cycle
    task automatic run_transaction(input logic [7:0] op, input logic [31:0] adr,
                                   input logic [31:0] wdat, input logic [31:0] expd);
        logic [1:0] gap;
        gap = 2'b00;
        repeat (2) begin
            lfsr = lfsr_step(lfsr);
            gap  = {gap[0], lfsr[0]};
        end
        repeat (gap) @(posedge wb_clk);
        @(posedge wb_clk);
        #1;
        exp_dat  = expd;
        wbs_adr  = adr;
        wbs_wdat = wdat;
        wbs_we   = (op == "w");
        wbs_sel  = 4'hf;
        wbs_cyc  = 1'b1;
        wbs_stb  = 1'b1;
        @(negedge wb_clk);
        while (!wbs_ack) begin
            @(negedge wb_clk);
        end
        @(posedge wb_clk);
        #1;
        wbs_cyc = 1'b0;
        wbs_stb = 1'b0;
        wbs_we  = 1'b0;
    endtask

    task automatic end_run();
        int chk_errs;
        chk_errs = u_knn_wb_top.u_wbs_ctrl.u_knn_wb_chk.fail_cnt;
        $display("error count: monitor %0d, assertions %0d, other %0d",
                 mon_errs, chk_errs, other_errs);
        if (mon_errs + chk_errs + other_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    initial begin
        wbs_cyc  = 1'b0;
        wbs_stb  = 1'b0;
        wbs_we   = 1'b0;
        wbs_sel  = 4'h0;
        wbs_adr  = '0;
        wbs_wdat = '0;
        exp_dat  = '0;
        lfsr     = LFSR_SEED;
        load_vectors();
        cycle_limit = op_q.size() * 8 + 50;
        @(negedge wb_rst);
        if (op_q.size() == 0) begin
            other_errs++;
            $display("no transactions read from %s", VEC_FILE);
        end else begin
            foreach (op_q[i]) begin
                run_transaction(op_q[i], adr_q[i], wdat_q[i], exp_q[i]);
            end
        end
        repeat (2) @(posedge wb_clk);
        end_run();
    end

    initial begin
        wait (cycle_limit > 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge wb_clk);
            cycle_cnt++;
        end
        other_errs++;
        $display("timeout: test did not finish within %0d cycles", cycle_limit);
        end_run();
    end

endmodule

//--- tests/knn_wb_chk.sv
`timescale 1ns/1ps

module knn_wb_chk (
    input  logic                   wb_clk_i,
    input  logic                   wb_rst_i,
    input  logic                   wbs_cyc_i,
    input  logic                   wbs_stb_i,
    input  logic                   wbs_we_i,
    input  logic                   ack_i,
    input  knn_wb_pkg::wbs_state_t state_i
);

    import knn_wb_pkg::*;

    int   fail_cnt = 0;
    logic rd_req;
    logic wr_req;

    // a request is only taken in idle
    assign rd_req = (state_i == idle) && wbs_cyc_i && wbs_stb_i && !wbs_we_i;
    assign wr_req = (state_i == idle) && wbs_cyc_i && wbs_stb_i && wbs_we_i;

    ack_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        ack_i |=> !ack_i)
    else begin
        fail_cnt++;
        $error("ack high for two cycles in a row");
    end

    ack_in_cycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        ack_i |-> (wbs_cyc_i && wbs_stb_i))
    else begin
        fail_cnt++;
        $error("ack high while cyc or stb is low");
    end

    ack_in_reset: assert property (@(posedge wb_clk_i)
        (wb_rst_i && $past(wb_rst_i)) |-> !ack_i)
    else begin
        fail_cnt++;
        $error("ack high during reset");
    end

    read_latency: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        $past(rd_req, 3) |-> ack_i)
    else begin
        fail_cnt++;
        $error("read ack missing three cycles after the request");
    end

    write_latency: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        $past(wr_req) |-> ack_i)
    else begin
        fail_cnt++;
        $error("write ack missing one cycle after the request");
    end

    ack_origin: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        ack_i |-> ($past(rd_req, 3) || $past(wr_req)))
    else begin
        fail_cnt++;
        $error("ack at a cycle that matches no request");
    end

endmodule

bind wbs_ctrl knn_wb_chk u_knn_wb_chk (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .wbs_cyc_i (wbs_cyc_i),
    .wbs_stb_i (wbs_stb_i),
    .wbs_we_i  (wbs_we_i),
    .ack_i     (wbs_ack_o),
    .state_i   (state_q)
);

//--- tests/knn_wb_monitor.sv
`timescale 1ns/1ps
`include "knn_wb_macros.svh"

module knn_wb_monitor (
    input  logic        wb_clk_i,
    input  logic        wb_rst_i,
    input  logic        wbs_cyc_i,
    input  logic        wbs_stb_i,
    input  logic        wbs_we_i,
    input  logic [31:0] wbs_adr_i,
    input  logic [31:0] wbs_dat_i,
    input  logic        ack_i,
    input  logic [31:0] rd_dat_i,
    input  logic        mode_i,
    input  logic        debug_i,
    input  logic        done_i,
    input  logic [31:0] exp_dat_i,
    output int          err_cnt_o
);

    int   err_cnt = 0;
    logic exp_mode;
    logic exp_debug;
    logic exp_done;

    assign err_cnt_o = err_cnt;

    task automatic compare(input string name, input logic [31:0] act, input logic [31:0] expd);
        if (act !== expd) begin
            err_cnt++;
            $display("FAILED time %0t: %s expected %0h, got %0h", $time, name, expd, act);
        end
    endtask

    // outputs and read data are sampled mid-cycle
    always @(negedge wb_clk_i) begin
        if (wb_rst_i) begin
            exp_mode  = 1'b0;
            exp_debug = 1'b0;
            exp_done  = 1'b0;
        end else begin
            compare("mode_o", {31'b0, mode_i}, {31'b0, exp_mode});
            compare("debug_o", {31'b0, debug_i}, {31'b0, exp_debug});
            compare("done_o", {31'b0, done_i}, {31'b0, exp_done});
            if (ack_i && !(wbs_cyc_i && wbs_stb_i)) begin
                err_cnt++;
                $display("ack seen at time %0t without an active request", $time);
            end
            if (ack_i && !wbs_we_i) begin
                compare("wbs_dat_o", rd_dat_i, exp_dat_i);
            end
            // control bits follow bit 0 from the edge that ends the ack
            if (ack_i && wbs_we_i) begin
                if (wbs_adr_i == `KNN_MODE_ADDR) begin
                    exp_mode = wbs_dat_i[0];
                end
                if (wbs_adr_i == `KNN_DEBUG_ADDR) begin
                    exp_debug = wbs_dat_i[0];
                end
                if (wbs_adr_i == `KNN_DONE_ADDR) begin
                    exp_done = wbs_dat_i[0];
                end
            end
        end
    end

endmodule

//--- tests/wb_clk_gen.sv
`timescale 1ns/1ps

module wb_clk_gen #(
    parameter int PERIOD_NS  = 8,
    parameter int RST_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // reset drops just after the last reset edge
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1;
        rst_o = 1'b0;
    end

endmodule

//--- hw/knn_wb_top.sv
`timescale 1ns/1ps
`include "knn_wb_macros.svh"

module knn_wb_top (
    input  logic                 wb_clk_i,
    input  logic                 wb_rst_i,

    input  logic                 wbs_cyc_i,
    input  logic                 wbs_stb_i,
    input  logic                 wbs_we_i,
    input  logic [3:0]           wbs_sel_i,
    input  knn_wb_pkg::wb_addr_t wbs_adr_i,
    input  knn_wb_pkg::wb_data_t wbs_dat_i,
    output logic                 wbs_ack_o,
    output knn_wb_pkg::wb_data_t wbs_dat_o,

    output logic                 mode_o,
    output logic                 debug_o,
    output logic                 done_o
);

    import knn_wb_pkg::*;

    logic                      qp_csb;
    logic                      qp_web;
    qp_addr_t                  qp_addr;
    patch_t                    qp_wdata;
    patch_t                    qp_rdata;

    logic [`KNN_LEAF_SIZE-1:0] leaf_csb;
    logic [`KNN_LEAF_SIZE-1:0] leaf_web;
    leaf_addr_t                leaf_addr;
    leaf_word_t                leaf_wdata;
    leaf_word_t                leaf_rdata [`KNN_LEAF_SIZE];

    logic                      node_csb;
    logic                      node_web;
    node_addr_t                node_addr;
    wb_data_t                  node_wdata;
    wb_data_t                  node_rdata;

    wbs_ctrl u_wbs_ctrl (
        .wb_clk_i     (wb_clk_i),
        .wb_rst_i     (wb_rst_i),
        .wbs_cyc_i    (wbs_cyc_i),
        .wbs_stb_i    (wbs_stb_i),
        .wbs_we_i     (wbs_we_i),
        .wbs_sel_i    (wbs_sel_i),
        .wbs_adr_i    (wbs_adr_i),
        .wbs_dat_i    (wbs_dat_i),
        .wbs_ack_o    (wbs_ack_o),
        .wbs_dat_o    (wbs_dat_o),
        .mode_o       (mode_o),
        .debug_o      (debug_o),
        .done_o       (done_o),
        .qp_csb_o     (qp_csb),
        .qp_web_o     (qp_web),
        .qp_addr_o    (qp_addr),
        .qp_wdata_o   (qp_wdata),
        .qp_rdata_i   (qp_rdata),
        .leaf_csb_o   (leaf_csb),
        .leaf_web_o   (leaf_web),
        .leaf_addr_o  (leaf_addr),
        .leaf_wdata_o (leaf_wdata),
        .leaf_rdata_i (leaf_rdata),
        .node_csb_o   (node_csb),
        .node_web_o   (node_web),
        .node_addr_o  (node_addr),
        .node_wdata_o (node_wdata),
        .node_rdata_i (node_rdata)
    );

    sram_1rw #(
        .DATA_W ($bits(patch_t)),
        .DEPTH  (`KNN_NUM_QUERYS)
    ) u_qp_mem (
        .wb_clk_i (wb_clk_i),
        .csb_i    (qp_csb),
        .web_i    (qp_web),
        .addr_i   (qp_addr),
        .wdata_i  (qp_wdata),
        .rdata_o  (qp_rdata)
    );

    sram_1rw #(
        .DATA_W ($bits(wb_data_t)),
        .DEPTH  (`KNN_NODE_DEPTH)
    ) u_node_mem (
        .wb_clk_i (wb_clk_i),
        .csb_i    (node_csb),
        .web_i    (node_web),
        .addr_i   (node_addr),
        .wdata_i  (node_wdata),
        .rdata_o  (node_rdata)
    );

    // banks share address and write word, selects are per bank
    for (genvar i = 0; i < `KNN_LEAF_SIZE; i++) begin : g_leaf
        sram_1rw #(
            .DATA_W ($bits(leaf_word_t)),
            .DEPTH  (`KNN_NUM_LEAVES)
        ) u_leaf_bank (
            .wb_clk_i (wb_clk_i),
            .csb_i    (leaf_csb[i]),
            .web_i    (leaf_web[i]),
            .addr_i   (leaf_addr),
            .wdata_i  (leaf_wdata),
            .rdata_o  (leaf_rdata[i])
        );
    end

endmodule

//--- hw/wbs_ctrl.sv
`timescale 1ns/1ps
`include "knn_wb_macros.svh"

module wbs_ctrl (
    input  logic                     wb_clk_i,
    input  logic                     wb_rst_i,

    input  logic                     wbs_cyc_i,
    input  logic                     wbs_stb_i,
    input  logic                     wbs_we_i,
    input  logic [3:0]               wbs_sel_i,
    input  knn_wb_pkg::wb_addr_t     wbs_adr_i,
    input  knn_wb_pkg::wb_data_t     wbs_dat_i,
    output logic                     wbs_ack_o,
    output knn_wb_pkg::wb_data_t     wbs_dat_o,

    output logic                     mode_o,
    output logic                     debug_o,
    output logic                     done_o,

    output logic                     qp_csb_o,
    output logic                     qp_web_o,
    output knn_wb_pkg::qp_addr_t     qp_addr_o,
    output knn_wb_pkg::patch_t       qp_wdata_o,
    input  knn_wb_pkg::patch_t       qp_rdata_i,

    output logic [`KNN_LEAF_SIZE-1:0] leaf_csb_o,
    output logic [`KNN_LEAF_SIZE-1:0] leaf_web_o,
    output knn_wb_pkg::leaf_addr_t   leaf_addr_o,
    output knn_wb_pkg::leaf_word_t   leaf_wdata_o,
    input  knn_wb_pkg::leaf_word_t   leaf_rdata_i [`KNN_LEAF_SIZE],

    output logic                     node_csb_o,
    output logic                     node_web_o,
    output knn_wb_pkg::node_addr_t   node_addr_o,
    output knn_wb_pkg::wb_data_t     node_wdata_o,
    input  knn_wb_pkg::wb_data_t     node_rdata_i
);

    import knn_wb_pkg::*;

    localparam int PATCH_W = $bits(patch_t);
    localparam int BANK_W  = $clog2(`KNN_LEAF_SIZE);

    wbs_state_t state_q;
    wbs_state_t state_d;

    logic                    wbs_valid;
    logic                    req_latch;
    logic                    we_q;
    wb_addr_t                adr_q;
    wb_data_t                dat_q;
    wb_data_t                low_q;
    logic                    ack_d;
    logic                    ack_q;
    wb_data_t                dat_o_d;
    wb_data_t                dat_o_q;
    logic                    dat_o_en;
    wb_addr_t                region;
    logic                    hit_query;
    logic                    hit_leaf;
    logic                    hit_node;
    logic [BANK_W-1:0]       leaf_bank;
    logic                    wr_cycle;

    assign wbs_valid = wbs_cyc_i & wbs_stb_i;
    assign wbs_ack_o = ack_q;
    assign wbs_dat_o = dat_o_q;

    assign region    = adr_q & `KNN_ADDR_MASK;
    assign hit_query = (region == `KNN_QUERY_BASE);
    assign hit_leaf  = (region == `KNN_LEAF_BASE);
    assign hit_node  = (region == `KNN_NODE_BASE);
    assign leaf_bank = adr_q[3 +: BANK_W];

    // write side effects all land on the edge that ends the ack cycle
    assign wr_cycle = (state_q == ack) && we_q;

    // bit 2 picks the 32-bit half and bits 1:0 are byte lanes
    assign qp_addr_o    = adr_q[3 +: $bits(qp_addr_t)];
    assign leaf_addr_o  = adr_q[11:6];
    assign node_addr_o  = adr_q[9:2];
    assign qp_wdata_o   = {dat_q[PATCH_W-33:0], low_q};
    assign leaf_wdata_o = {dat_q, low_q};
    assign node_wdata_o = dat_q;

    always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
        if (wb_rst_i) begin
            state_q <= idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d    = state_q;
        req_latch  = 1'b0;
        ack_d      = 1'b0;
        dat_o_d    = '0;
        dat_o_en   = 1'b0;
        qp_csb_o   = 1'b1;
        qp_web_o   = 1'b1;
        leaf_csb_o = '1;
        leaf_web_o = '1;
        node_csb_o = 1'b1;
        node_web_o = 1'b1;

        unique case (state_q)
            idle: begin
                if (wbs_valid) begin
                    req_latch = 1'b1;
                    if (wbs_we_i) begin
                        ack_d   = 1'b1;
                        state_d = ack;
                    end else begin
                        state_d = read_mem;
                    end
                end
            end

            read_mem: begin
                state_d = reg_mem_read;
                if (hit_query) begin
                    qp_csb_o = 1'b0;
                end else if (hit_leaf) begin
                    leaf_csb_o[leaf_bank] = 1'b0;
                end else if (hit_node) begin
                    node_csb_o = 1'b0;
                end
            end

            reg_mem_read: begin
                state_d  = ack;
                ack_d    = 1'b1;
                dat_o_en = 1'b1;
                if (hit_query) begin
                    // upper half of a patch is only 23 bits wide
                    dat_o_d = adr_q[2] ? {{(64 - PATCH_W){1'b0}}, qp_rdata_i[PATCH_W-1:32]}
                                       : qp_rdata_i[31:0];
                end else if (hit_leaf) begin
                    dat_o_d = adr_q[2] ? leaf_rdata_i[leaf_bank][63:32]
                                       : leaf_rdata_i[leaf_bank][31:0];
                end else if (hit_node) begin
                    dat_o_d = node_rdata_i;
                end else if (adr_q == `KNN_MODE_ADDR) begin
                    dat_o_d = {31'b0, mode_o};
                end else if (adr_q == `KNN_DEBUG_ADDR) begin
                    dat_o_d = {31'b0, debug_o};
                end else if (adr_q == `KNN_DONE_ADDR) begin
                    dat_o_d = {31'b0, done_o};
                end
            end

            ack: begin
                state_d = idle;
                if (we_q) begin
                    if (hit_query && adr_q[2]) begin
                        qp_csb_o = 1'b0;
                        qp_web_o = 1'b0;
                    end else if (hit_leaf && adr_q[2]) begin
                        leaf_csb_o[leaf_bank] = 1'b0;
                        leaf_web_o[leaf_bank] = 1'b0;
                    end else if (hit_node) begin
                        node_csb_o = 1'b0;
                        node_web_o = 1'b0;
                    end
                end
            end
        endcase
    end

    always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
        if (wb_rst_i) begin
            we_q  <= 1'b0;
            adr_q <= '0;
        end else if (req_latch) begin
            we_q  <= wbs_we_i;
            adr_q <= wbs_adr_i;
        end
    end

    // write data of the request, used in the ack cycle
    always_ff @(posedge wb_clk_i) begin
        if (req_latch) begin
            dat_q <= wbs_dat_i;
        end
    end

    // low word of a two-step query or leaf write
    always_ff @(posedge wb_clk_i) begin
        if (wr_cycle && !adr_q[2] && (hit_query || hit_leaf)) begin
            low_q <= dat_q;
        end
    end

    always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
        if (wb_rst_i) begin
            ack_q   <= 1'b0;
            dat_o_q <= '0;
        end else begin
            ack_q <= ack_d;
            if (dat_o_en) begin
                dat_o_q <= dat_o_d;
            end
        end
    end

    // accelerator control bits
    always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
        if (wb_rst_i) begin
            mode_o  <= 1'b0;
            debug_o <= 1'b0;
            done_o  <= 1'b0;
        end else if (wr_cycle) begin
            if (adr_q == `KNN_MODE_ADDR) begin
                mode_o <= dat_q[0];
            end
            if (adr_q == `KNN_DEBUG_ADDR) begin
                debug_o <= dat_q[0];
            end
            if (adr_q == `KNN_DONE_ADDR) begin
                done_o <= dat_q[0];
            end
        end
    end

endmodule

//--- hw/sram_1rw.sv
`timescale 1ns/1ps

module sram_1rw #(
    parameter int DATA_W = 32,
    parameter int DEPTH  = 256
) (
    input  logic                     wb_clk_i,
    input  logic                     csb_i,
    input  logic                     web_i,
    input  logic [$clog2(DEPTH)-1:0] addr_i,
    input  logic [DATA_W-1:0]        wdata_i,
    output logic [DATA_W-1:0]        rdata_o
);

    logic [DATA_W-1:0] mem [DEPTH];

    // write port, addresses past DEPTH are dropped
    always_ff @(posedge wb_clk_i) begin
        if (!csb_i && !web_i) begin
            if (int'(addr_i) < DEPTH) begin
                mem[addr_i] <= wdata_i;
            end
        end
    end

    // read data appears on the edge after a selected read and then holds
    always_ff @(posedge wb_clk_i) begin
        if (!csb_i && web_i) begin
            rdata_o <= mem[addr_i];
        end
    end

endmodule

//--- hw/knn_wb_pkg.sv
`include "knn_wb_macros.svh"

package knn_wb_pkg;

    // wishbone bus
    typedef logic [31:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;

    // five packed 11-bit values
    typedef logic [`KNN_DATA_W*`KNN_PATCH_SIZE-1:0] patch_t;

    // one leaf entry, written as two bus words
    typedef logic [63:0] leaf_word_t;

    // memory word addresses
    typedef logic [$clog2(`KNN_NUM_QUERYS)-1:0] qp_addr_t;
    typedef logic [$clog2(`KNN_NUM_LEAVES)-1:0] leaf_addr_t;
    typedef logic [$clog2(`KNN_NODE_DEPTH)-1:0] node_addr_t;

    // bus controller states
    typedef enum logic [1:0] {
        idle,
        read_mem,
        reg_mem_read,
        ack
    } wbs_state_t;

endpackage

//--- hw/knn_wb_macros.svh
`ifndef KNN_WB_MACROS_SVH
`define KNN_WB_MACROS_SVH

// patch geometry
`define KNN_DATA_W       11
`define KNN_PATCH_SIZE   5

// leaf banks, one per patch slot in a leaf
`define KNN_LEAF_SIZE    8
`define KNN_NUM_LEAVES   64

// query memory holds a 26 x 19 grid of patches
`define KNN_NUM_QUERYS   494
`define KNN_NODE_DEPTH   256

// region decode uses the upper half of the address
`define KNN_ADDR_MASK    32'hFFFF_0000

// control bits, full-address match
`define KNN_MODE_ADDR    32'h3000_0000
`define KNN_DEBUG_ADDR   32'h3000_0004
`define KNN_DONE_ADDR    32'h3000_0008

// memory regions
`define KNN_QUERY_BASE   32'h3001_0000
`define KNN_LEAF_BASE    32'h3002_0000
`define KNN_NODE_BASE    32'h3004_0000

`endif
